// File: common/fnd_pkg.sv
package fnd_pkg;

    // display positions, digit 0 is the rightmost
    localparam int NUM_DIGITS = 4;

    // word offsets, taken from paddr[3:2]
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_VALUE  = 2'd1;
    localparam logic [1:0] REG_DP     = 2'd2;
    localparam logic [1:0] REG_STATUS = 2'd3; // read only, busy in bit 0

    // anything larger shows as this
    localparam logic [13:0] MAX_DISPLAY = 14'd9999;

    // register contents going to the display path
    typedef struct packed {
        logic        enable;
        logic [13:0] value;
        logic [3:0]  dp_mask;   // bit i lights the point of digit i
    } fnd_cfg_t;

    // converter result, d0 is the ones digit
    typedef struct packed {
        logic [3:0] d3;
        logic [3:0] d2;
        logic [3:0] d1;
        logic [3:0] d0;
    } bcd_digits_t;

endpackage

// File: fnd_apb/fnd_apb_regs.sv
module fnd_apb_regs import fnd_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    input  logic        busy,
    output logic [31:0] prdata,
    output logic        pready,
    output fnd_cfg_t    cfg,
    output logic        value_wr
);

    logic        access;    // first access-phase cycle, before pready
    logic [1:0]  reg_sel;
    logic [31:0] rd_data;

    assign reg_sel = paddr[3:2];
    assign access  = psel && penable && !pready;

    // readback, zero-extended
    always_comb begin
        case (reg_sel)
            REG_CTRL:   rd_data = {31'd0, cfg.enable};
            REG_VALUE:  rd_data = {18'd0, cfg.value};
            REG_DP:     rd_data = {28'd0, cfg.dp_mask};
            REG_STATUS: rd_data = {31'd0, busy};
            default:    rd_data = 32'd0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pready   <= 1'b0;
            prdata   <= 32'd0;
            value_wr <= 1'b0;
            cfg      <= '0;
        end else begin
            pready   <= access; // one wait state
            prdata   <= 32'd0;
            value_wr <= 1'b0;
            if (access && !pwrite) begin
                prdata <= rd_data;
            end
            if (access && pwrite) begin
                case (reg_sel)
                    REG_CTRL:  cfg.enable  <= pwdata[0];
                    REG_VALUE: begin
                        cfg.value <= pwdata[13:0];
                        value_wr  <= 1'b1;
                    end
                    REG_DP:    cfg.dp_mask <= pwdata[3:0];
                    default:   ; // status ignores writes
                endcase
            end
        end
    end

    // master holds the access phase through pready, so only one pulse per transfer
    a_pready_single: assert property (
        @(posedge clk) disable iff (reset) pready |=> !pready
    );

    // read data is only valid with pready
    a_prdata_idle_zero: assert property (
        @(posedge clk) disable iff (reset) !pready |-> (prdata == 32'd0)
    );

endmodule

// File: fnd_bcd/bcd_converter.sv
module bcd_converter import fnd_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        value_wr,
    input  logic [13:0] value,
    output bcd_digits_t digits,
    output logic        busy
);

    localparam int BIN_W  = 14;
    localparam int BCD_W  = 4 * NUM_DIGITS;
    localparam int STEPS  = BIN_W;

    logic [BCD_W+BIN_W-1:0] sr;         // {bcd, remaining binary}
    logic [BCD_W+BIN_W-1:0] sr_next;
    logic [3:0]             step_cnt;
    logic [13:0]            clamped;

    assign clamped = (value > MAX_DISPLAY) ? MAX_DISPLAY : value;

    // one shift-and-add-3 step
    always_comb begin
        sr_next = sr;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (sr_next[BIN_W + 4*i +: 4] >= 4'd5) begin
                sr_next[BIN_W + 4*i +: 4] = sr_next[BIN_W + 4*i +: 4] + 4'd3;
            end
        end
        sr_next = sr_next << 1;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            step_cnt <= 4'd0;
            sr       <= '0;
            digits   <= '0;
        end else if (value_wr) begin
            // new value restarts any conversion in flight
            busy     <= 1'b1;
            step_cnt <= 4'd0;
            sr       <= {{BCD_W{1'b0}}, clamped};
        end else if (busy) begin
            sr       <= sr_next;
            step_cnt <= step_cnt + 4'd1;
            if (step_cnt == 4'(STEPS - 1)) begin
                busy   <= 1'b0;
                digits <= bcd_digits_t'(sr_next[BIN_W +: BCD_W]); // last step
            end
        end
    end

    // clamp plus add-3 keeps every published nibble decimal
    a_digits_decimal: assert property (
        @(posedge clk) disable iff (reset)
        $fell(busy) |-> (digits.d0 <= 4'd9 && digits.d1 <= 4'd9 &&
                         digits.d2 <= 4'd9 && digits.d3 <= 4'd9)
    );

endmodule

// File: verilog/scan_timer.sv
module scan_timer #(
    parameter int TICK_DIV = 50000
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] count;

    assign tick = (count == '0); // reload cycle

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= CNT_W'(TICK_DIV - 1);
        end else if (count == '0) begin
            count <= CNT_W'(TICK_DIV - 1);
        end else begin
            count <= count - 1'b1;
        end
    end

endmodule

// File: verilog/digit_scan_fsm.sv
module digit_scan_fsm import fnd_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       tick,
    input  logic       enable,
    output logic [1:0] digit_sel,
    output logic [3:0] fnd_comm
);

    typedef enum logic {
        BLANK,
        SCAN
    } scan_state_t;

    scan_state_t state;
    logic [1:0]  sel_next;

    // wrap after the last position
    assign sel_next = (digit_sel == 2'(NUM_DIGITS - 1)) ? 2'd0 : digit_sel + 2'd1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= BLANK;
            digit_sel <= 2'd0;
            fnd_comm  <= 4'hf;
        end else begin
            case (state)
                BLANK: begin
                    digit_sel <= 2'd0;
                    fnd_comm  <= 4'hf;
                    if (enable && tick) begin
                        state    <= SCAN;
                        fnd_comm <= 4'b1110; // start at digit 0
                    end
                end
                SCAN: begin
                    if (!enable) begin
                        state     <= BLANK;
                        digit_sel <= 2'd0;
                        fnd_comm  <= 4'hf;
                    end else if (tick) begin
                        digit_sel <= sel_next;
                        fnd_comm  <= ~(4'b0001 << sel_next); // active low
                    end
                end
                default: state <= BLANK;
            endcase
        end
    end

    // never two digits lit at once
    a_comm_one_cold: assert property (
        @(posedge clk) disable iff (reset)
        (fnd_comm == 4'hf) || $onehot(~fnd_comm)
    );

endmodule

// File: verilog/seg_encoder.sv
module seg_encoder import fnd_pkg::*; (
    input  logic [1:0]  digit_sel,
    input  bcd_digits_t digits,
    input  logic [3:0]  dp_mask,
    output logic [7:0]  fnd_font
);

    logic [NUM_DIGITS-1:0][3:0] digit_arr;
    logic [3:0]                 bcd;
    logic [6:0]                 seg;   // active low, a in bit 0

    assign digit_arr = digits;   // d0 lands at index 0
    assign bcd       = digit_arr[digit_sel];

    always_comb begin
        case (bcd)
            4'd0:    seg = 7'b1000000;
            4'd1:    seg = 7'b1111001;
            4'd2:    seg = 7'b0100100;
            4'd3:    seg = 7'b0110000;
            4'd4:    seg = 7'b0011001;
            4'd5:    seg = 7'b0010010;
            4'd6:    seg = 7'b0000010;
            4'd7:    seg = 7'b1111000;
            4'd8:    seg = 7'b0000000;
            4'd9:    seg = 7'b0010000;
            default: seg = 7'b1111111; // blank
        endcase
    end

    // point is active low as well
    assign fnd_font = {~dp_mask[digit_sel], seg};

endmodule

// File: verilog/fnd_periph.sv
module fnd_periph import fnd_pkg::*; #(
    parameter int TICK_DIV = 50000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic [3:0]  fnd_comm,
    output logic [7:0]  fnd_font
);

    fnd_cfg_t    cfg;
    bcd_digits_t digits;
    logic        value_wr;
    logic        busy;
    logic        tick;
    logic [1:0]  digit_sel;

    fnd_apb_regs u_regs (
        .clk      (clk),
        .reset    (reset),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .busy     (busy),
        .prdata   (prdata),
        .pready   (pready),
        .cfg      (cfg),
        .value_wr (value_wr)
    );

    bcd_converter u_bcd (
        .clk      (clk),
        .reset    (reset),
        .value_wr (value_wr),
        .value    (cfg.value),
        .digits   (digits),
        .busy     (busy)
    );

    scan_timer #(
        .TICK_DIV (TICK_DIV)
    ) u_timer (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    digit_scan_fsm u_scan (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .enable    (cfg.enable),
        .digit_sel (digit_sel),
        .fnd_comm  (fnd_comm)
    );

    seg_encoder u_enc (
        .digit_sel (digit_sel),
        .digits    (digits),
        .dp_mask   (cfg.dp_mask),
        .fnd_font  (fnd_font)
    );

endmodule

// File: testbench/tb_fnd_periph.sv
module tb_fnd_periph import fnd_pkg::*;;

    localparam int TICK_DIV   = 8;
    localparam int NUM_RANDOM = 20;
    localparam int NUM_DP     = 3;
    // readback, blank, random values, two clamps, dp masks, restart
    localparam int NUM_TESTS  = 1 + 1 + NUM_RANDOM + 2 + NUM_DP + 1;

    logic        clk;
    logic        reset;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic [3:0]  fnd_comm;
    logic [7:0]  fnd_font;

    string       test_name = "reset";
    logic        check_en = 1'b0;   // comparator armed
    int          exp_value = 0;
    logic [3:0]  exp_dp = 4'd0;
    logic [3:0]  seen = 4'd0;       // digits checked since arming
    int          cur_value = 0;
    logic [3:0]  cur_dp = 4'd0;
    int          xfer_count = 0;
    int          pready_cycles = 0;

    fnd_periph #(
        .TICK_DIV (TICK_DIV)
    ) UUT (
        .clk      (clk),
        .reset    (reset),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .fnd_comm (fnd_comm),
        .fnd_font (fnd_font)
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("Fail %s: %s expected %h actual %h",
                               test_name, what, expected, actual));
        end
    endtask

    // display model: clamp, pick the decimal digit, active-low segments
    function automatic logic [7:0] expected_font(input int value, input logic [3:0] dp,
                                                 input int idx);
        int         v;
        int         d;
        logic [6:0] lit;    // active high, gfedcba
        v = (value > 9999) ? 9999 : value;
        for (int i = 0; i < idx; i++) begin
            v = v / 10;
        end
        d = v % 10;
        case (d)
            0: lit = 7'h3f;
            1: lit = 7'h06;
            2: lit = 7'h5b;
            3: lit = 7'h4f;
            4: lit = 7'h66;
            5: lit = 7'h6d;
            6: lit = 7'h7d;
            7: lit = 7'h07;
            8: lit = 7'h7f;
            default: lit = 7'h6f;
        endcase
        return {~dp[idx], ~lit};
    endfunction

    function automatic int lit_index(input logic [3:0] comm);
        int idx;
        idx = 0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (!comm[i]) idx = i;
        end
        return idx;
    endfunction

    function automatic logic [3:0] addr_of(input logic [1:0] reg_off);
        return {reg_off, 2'b00};
    endfunction

    // compares every lit digit against the model
    always @(posedge clk) begin
        if (!reset) begin
            if (fnd_comm != 4'hf && !$onehot(~fnd_comm)) begin
                fail_run($sformatf("fnd_comm %b lights more than one digit", fnd_comm));
            end else if (check_en && fnd_comm != 4'hf) begin
                seen <= seen | (4'b0001 << lit_index(fnd_comm));
                check_equal($sformatf("digit %0d of %0d", lit_index(fnd_comm), exp_value),
                            32'(expected_font(exp_value, exp_dp, lit_index(fnd_comm))),
                            32'(fnd_font));
            end
        end
    end

    always @(posedge clk) begin
        if (pready) pready_cycles <= pready_cycles + 1;
    end

    initial begin
        #(NUM_TESTS * (200 + 4 * TICK_DIV) * 10);
        fail_run("timeout: the tests did not finish in time");
    end

    task automatic apb_xfer(input logic [1:0] reg_off, input logic wr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        paddr   <= addr_of(reg_off);
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready) @(posedge clk);
        rdata   = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
        xfer_count++;
    endtask

    task automatic apb_write(input logic [1:0] reg_off, input logic [31:0] wdata);
        logic [31:0] unused;
        apb_xfer(reg_off, 1'b1, wdata, unused);
    endtask

    task automatic apb_read(input logic [1:0] reg_off, output logic [31:0] rdata);
        apb_xfer(reg_off, 1'b0, 32'd0, rdata);
    endtask

    task automatic wait_conversion();
        logic [31:0] st;
        st = 32'd1;
        while (st[0]) apb_read(REG_STATUS, st);
    endtask

    task automatic arm_checks();
        exp_value <= cur_value;
        exp_dp    <= cur_dp;
        seen      <= 4'd0;
        check_en  <= 1'b1;
    endtask

    task automatic wait_full_scan();
        @(posedge clk);
        while (seen != 4'hf) @(posedge clk);
    endtask

    task automatic show_value(input int v);
        check_en <= 1'b0;
        apb_write(REG_VALUE, v);
        wait_conversion();
        cur_value = v;
        arm_checks();
        wait_full_scan();
    endtask

    task automatic expect_blank(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            check_equal("fnd_comm while disabled", 32'hf, 32'(fnd_comm));
        end
    endtask

    initial begin
        logic [31:0] rd;
        clk     = 1'b0;
        reset   = 1'b1;
        paddr   = 4'd0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = 32'd0;
        void'($urandom(32'h10c5));
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        test_name = "register readback";
        apb_write(REG_CTRL, 32'hffff_ffff);
        apb_write(REG_VALUE, 32'hffff_ffff);
        apb_read(REG_STATUS, rd);
        check_equal("status during conversion", 32'd1, rd);
        apb_write(REG_DP, 32'hffff_fffb);
        apb_write(REG_STATUS, 32'hffff_ffff);   // read only
        apb_read(REG_CTRL, rd);
        check_equal("ctrl", 32'd1, rd);
        apb_read(REG_VALUE, rd);
        check_equal("value", 32'h3fff, rd);
        apb_read(REG_DP, rd);
        check_equal("dp", 32'hb, rd);
        repeat (20) @(posedge clk);
        apb_read(REG_STATUS, rd);
        check_equal("status when idle", 32'd0, rd);

        test_name = "disabled display";
        apb_write(REG_CTRL, 32'd0);
        expect_blank(4 * TICK_DIV);
        apb_write(REG_VALUE, 32'd1234);
        expect_blank(4 * TICK_DIV + 8);
        wait_conversion();

        test_name = "decimal display";
        cur_dp = 4'd0;
        apb_write(REG_DP, 32'd0);
        apb_write(REG_CTRL, 32'd1);
        repeat (NUM_RANDOM) show_value($urandom % 10000);

        test_name = "clamping";
        show_value(10000);
        show_value(16383);

        test_name = "decimal points";
        repeat (NUM_DP) begin
            check_en <= 1'b0;
            cur_dp = 4'(($urandom % 15) + 1);
            apb_write(REG_DP, 32'(cur_dp));
            show_value($urandom % 10000);
        end

        test_name = "restart";
        check_en <= 1'b0;
        apb_write(REG_VALUE, 32'd4321);
        apb_write(REG_VALUE, 32'd807);   // lands mid conversion
        wait_conversion();
        cur_value = 807;
        arm_checks();
        wait_full_scan();

        test_name = "bus handshake";
        repeat (2) @(posedge clk);
        check_equal("pready cycles", 32'(xfer_count), 32'(pready_cycles));

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: project.f
common/fnd_pkg.sv
fnd_apb/fnd_apb_regs.sv
fnd_bcd/bcd_converter.sv
verilog/scan_timer.sv
verilog/digit_scan_fsm.sv
verilog/seg_encoder.sv
verilog/fnd_periph.sv
testbench/tb_fnd_periph.sv

// File: Makefile
TOP := tb_fnd_periph

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f project.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '=== PASS ==='

clean:
	rm -rf obj_dir
